// File: logic/core_pkg.sv
/* Core package
   Widths, RV32I opcodes, ALU operations and the stage payloads */
package core_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // Decoder to operand fetch
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  use_rs1;  // Else op1_base
    logic                  use_rs2;  // Else imm
    logic [XLEN-1:0]       op1_base; // PC for AUIPC, zero otherwise
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
  } dec_op_t;

  // Operand fetch to execute
  typedef struct packed {
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_e               alu_op;
  } exe_op_t;

endpackage

// File: logic/stream_slice.sv
/* Stream slice
   Two-entry skid buffer with registered outputs and flush */
module stream_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     skid_valid;
  payload_t skid_data;
  logic     out_free;
  logic     load_out;
  logic     load_skid;

  assign in_ready = !skid_valid; // Only the skid entry stalls input
  assign out_free = out_ready || !out_valid;

  // Output refills from skid first, else straight from input
  assign load_out  = out_free && (skid_valid || in_valid);
  assign load_skid = !out_free && in_valid && !skid_valid;

  always_ff @(posedge clk) begin
    if (!rst || flush) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      out_valid  <= skid_valid || in_valid;
      skid_valid <= 1'b0;
    end else if (load_skid) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_out) out_data <= skid_valid ? skid_data : in_data;
    if (load_skid) skid_data <= in_data;
  end

endmodule

// File: logic/inst_decoder.sv
/* Instruction decoder
   Decodes RV32I words, tracks pending registers and issues decoded operations */
module inst_decoder #(
  parameter int RF_DEPTH = 32
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             flush,
  input  logic                             instr_valid,
  input  logic [core_pkg::XLEN-1:0]        instr_word,
  input  logic [core_pkg::XLEN-1:0]        instr_pc,
  output logic                             instr_ready,
  input  logic                             wb_valid,
  input  logic [core_pkg::REG_ADDR_W-1:0]  wb_rd,
  output logic                             dec_valid,
  input  logic                             dec_ready,
  output core_pkg::dec_op_t                dec_op
);

  logic [RF_DEPTH-1:0] busy, busy_clr, busy_next;
  logic                live; // Low in reset, holds off input
  logic                out_free;
  logic                hazard;
  logic                accept;
  core_pkg::dec_op_t   dec_next;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic                alt; // funct7 bit 5

  // Registers past RF_DEPTH map to x0
  function automatic logic [core_pkg::REG_ADDR_W-1:0] reg_idx(
    input logic [core_pkg::REG_ADDR_W-1:0] idx
  );
    return (int'(idx) < RF_DEPTH) ? idx : '0;
  endfunction

  function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt_bit,
                                                input logic sub_ok);
    case (f3)
      3'b000:  return (alt_bit && sub_ok) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      3'b001:  return core_pkg::ALU_SLL;
      3'b010:  return core_pkg::ALU_SLT;
      3'b011:  return core_pkg::ALU_SLTU;
      3'b100:  return core_pkg::ALU_XOR;
      3'b101:  return alt_bit ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110:  return core_pkg::ALU_OR;
      default: return core_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = instr_word[6:0];
  assign funct3 = instr_word[14:12];
  assign alt    = instr_word[30];

  always_comb begin
    dec_next = '0; // Unknown opcodes become a no-op writing x0
    dec_next.alu_op = core_pkg::ALU_ADD;
    case (opcode)
      core_pkg::OPC_OP: begin
        dec_next.rs1     = reg_idx(instr_word[19:15]);
        dec_next.rs2     = reg_idx(instr_word[24:20]);
        dec_next.rd      = reg_idx(instr_word[11:7]);
        dec_next.use_rs1 = 1'b1;
        dec_next.use_rs2 = 1'b1;
        dec_next.alu_op  = alu_sel(funct3, alt, 1'b1);
      end
      core_pkg::OPC_OP_IMM: begin
        dec_next.rs1     = reg_idx(instr_word[19:15]);
        dec_next.rd      = reg_idx(instr_word[11:7]);
        dec_next.use_rs1 = 1'b1;
        dec_next.imm     = {{20{instr_word[31]}}, instr_word[31:20]};
        dec_next.alu_op  = alu_sel(funct3, alt, 1'b0); // No subi
      end
      core_pkg::OPC_LUI, core_pkg::OPC_AUIPC: begin
        dec_next.rd       = reg_idx(instr_word[11:7]);
        dec_next.imm      = {instr_word[31:12], 12'b0};
        dec_next.op1_base = (opcode == core_pkg::OPC_AUIPC) ? instr_pc : '0;
      end
      default: ;
    endcase
  end

  // Write-back frees its register in the same cycle
  always_comb begin
    busy_clr = busy;
    if (wb_valid && wb_rd != '0) busy_clr[wb_rd] = 1'b0;
  end

  assign hazard = (dec_next.use_rs1 && busy_clr[dec_next.rs1]) ||
                  (dec_next.use_rs2 && busy_clr[dec_next.rs2]) ||
                  busy_clr[dec_next.rd];

  assign out_free    = !dec_valid || dec_ready;
  assign instr_ready = live && out_free && !hazard && !flush;
  assign accept      = instr_valid && instr_ready;

  always_comb begin
    busy_next = busy_clr;
    if (accept && dec_next.rd != '0) busy_next[dec_next.rd] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      live      <= 1'b0;
      dec_valid <= 1'b0;
      busy      <= '0;
    end else begin
      live <= 1'b1;
      if (flush) begin
        dec_valid <= 1'b0;
        busy      <= '0;
      end else begin
        if (out_free) dec_valid <= accept;
        busy <= busy_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) dec_op <= dec_next;
  end

endmodule

// File: logic/operand_fetch.sv
/* Operand fetch
   Register file read and operand select, registered through a skid slice */
module operand_fetch #(
  parameter int RF_DEPTH = 32
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush,
  input  logic                            dec_valid,
  input  core_pkg::dec_op_t               dec_op,
  output logic                            dec_ready,
  output logic                            exe_valid,
  input  logic                            exe_ready,
  output core_pkg::exe_op_t               exe_op,
  input  logic                            wb_valid,
  input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
  input  logic [core_pkg::XLEN-1:0]       wb_data
);

  logic [core_pkg::XLEN-1:0] rf_mem [RF_DEPTH];
  logic [core_pkg::XLEN-1:0] rs1_data;
  logic [core_pkg::XLEN-1:0] rs2_data;
  core_pkg::exe_op_t         fetch_op;

  // Registers start at zero
  initial begin
    for (int i = 0; i < RF_DEPTH; i++) begin
      rf_mem[i] = '0;
    end
  end

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wb_valid && wb_rd != '0) rf_mem[wb_rd] <= wb_data;
  end

  assign rs1_data = rf_mem[dec_op.rs1];
  assign rs2_data = rf_mem[dec_op.rs2];

  always_comb begin
    fetch_op.op1    = dec_op.use_rs1 ? rs1_data : dec_op.op1_base;
    fetch_op.op2    = dec_op.use_rs2 ? rs2_data : dec_op.imm;
    fetch_op.rd     = dec_op.rd;
    fetch_op.alu_op = dec_op.alu_op;
  end

  // Slice registers the operands, so exe_valid follows one cycle later
  stream_slice #(
    .payload_t(core_pkg::exe_op_t)
  ) i_exe_slice (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .in_valid (dec_valid),
    .in_data  (fetch_op),
    .in_ready (dec_ready),
    .out_valid(exe_valid),
    .out_ready(exe_ready),
    .out_data (exe_op)
  );

endmodule

// File: logic/exec_unit.sv
/* Execute unit
   Integer ALU feeding the result register that drives write-back */
module exec_unit (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush,
  input  logic                            exe_valid,
  input  core_pkg::exe_op_t               exe_op,
  output logic                            exe_ready,
  output logic                            result_valid,
  input  logic                            result_ready,
  output logic [core_pkg::REG_ADDR_W-1:0] result_rd,
  output logic [core_pkg::XLEN-1:0]       result_data
);

  logic [core_pkg::XLEN-1:0] op1;
  logic [core_pkg::XLEN-1:0] op2;
  logic [4:0]                shamt;
  logic [core_pkg::XLEN-1:0] alu_out;
  logic                      load;

  assign op1   = exe_op.op1;
  assign op2   = exe_op.op2;
  assign shamt = op2[4:0];

  always_comb begin
    case (exe_op.alu_op)
      core_pkg::ALU_ADD:  alu_out = op1 + op2;
      core_pkg::ALU_SUB:  alu_out = op1 - op2;
      core_pkg::ALU_AND:  alu_out = op1 & op2;
      core_pkg::ALU_OR:   alu_out = op1 | op2;
      core_pkg::ALU_XOR:  alu_out = op1 ^ op2;
      core_pkg::ALU_SLT:  alu_out = {{(core_pkg::XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      core_pkg::ALU_SLTU: alu_out = {{(core_pkg::XLEN-1){1'b0}}, op1 < op2};
      core_pkg::ALU_SLL:  alu_out = op1 << shamt;
      core_pkg::ALU_SRL:  alu_out = op1 >> shamt;
      core_pkg::ALU_SRA:  alu_out = $unsigned($signed(op1) >>> shamt);
      default:            alu_out = '0;
    endcase
  end

  // Result register empty or draining this cycle
  assign exe_ready = !result_valid || result_ready;
  assign load      = exe_valid && exe_ready && !flush;

  always_ff @(posedge clk) begin
    if (!rst) begin
      result_valid <= 1'b0;
    end else if (exe_ready) begin
      result_valid <= load;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      result_rd   <= exe_op.rd;
      result_data <= alu_out;
    end
  end

endmodule

// File: logic/operand_core.sv
/* Operand core
   Decode, operand fetch and execute slice of an RV32I pipeline */
module operand_core #(
  parameter int RF_DEPTH = 32
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush,
  input  logic                            instr_valid,
  input  logic [core_pkg::XLEN-1:0]       instr_word,
  input  logic [core_pkg::XLEN-1:0]       instr_pc,
  output logic                            instr_ready,
  output logic                            result_valid,
  input  logic                            result_ready,
  output logic [core_pkg::REG_ADDR_W-1:0] result_rd,
  output logic [core_pkg::XLEN-1:0]       result_data
);

  logic              dec_valid, dec_ready;
  core_pkg::dec_op_t dec_op;
  logic              exe_valid, exe_ready;
  core_pkg::exe_op_t exe_op;
  logic              wb_done;

  // Write-back happens only on the result transfer
  assign wb_done = result_valid && result_ready;

  inst_decoder #(
    .RF_DEPTH(RF_DEPTH)
  ) i_inst_decoder (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .instr_valid(instr_valid),
    .instr_word (instr_word),
    .instr_pc   (instr_pc),
    .instr_ready(instr_ready),
    .wb_valid   (wb_done),
    .wb_rd      (result_rd),
    .dec_valid  (dec_valid),
    .dec_ready  (dec_ready),
    .dec_op     (dec_op)
  );

  operand_fetch #(
    .RF_DEPTH(RF_DEPTH)
  ) i_operand_fetch (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .dec_valid(dec_valid),
    .dec_op   (dec_op),
    .dec_ready(dec_ready),
    .exe_valid(exe_valid),
    .exe_ready(exe_ready),
    .exe_op   (exe_op),
    .wb_valid (wb_done),
    .wb_rd    (result_rd),
    .wb_data  (result_data)
  );

  exec_unit i_exec_unit (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .exe_valid   (exe_valid),
    .exe_op      (exe_op),
    .exe_ready   (exe_ready),
    .result_valid(result_valid),
    .result_ready(result_ready),
    .result_rd   (result_rd),
    .result_data (result_data)
  );

endmodule

// File: tests/operand_core_assert.sv
/* Operand core checker
   Reference model of the result stream and concurrent assertions on the top level */
module operand_core_assert (
  input logic                            clk,
  input logic                            rst,
  input logic                            flush,
  input logic                            instr_valid,
  input logic [core_pkg::XLEN-1:0]       instr_word,
  input logic [core_pkg::XLEN-1:0]       instr_pc,
  input logic                            instr_ready,
  input logic                            result_valid,
  input logic                            result_ready,
  input logic [core_pkg::REG_ADDR_W-1:0] result_rd,
  input logic [core_pkg::XLEN-1:0]       result_data
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int BUF_DEPTH = 8; // At most four in flight

  logic [31:0] model_rf [32];
  logic [31:0] buf_word [BUF_DEPTH];
  logic [31:0] buf_pc [BUF_DEPTH];
  logic [3:0]  head;
  logic [3:0]  tail;
  logic [3:0]  in_flight;
  logic        res_xfer;
  logic        accept;
  logic        idle;
  logic        in_reset_q = 1'b0;
  logic [31:0] pend_mask;
  logic        word_hazard;
  logic [4:0]  exp_rd;
  logic [31:0] exp_data;
  int          fail_count = 0;

  function automatic logic [4:0] model_rd(input logic [31:0] w);
    case (w[6:0])
      core_pkg::OPC_OP, core_pkg::OPC_OP_IMM: return w[11:7];
      core_pkg::OPC_LUI, core_pkg::OPC_AUIPC: return w[11:7];
      default:                                return 5'd0; // No destination
    endcase
  endfunction

  // RV32I result from the committed model state
  function automatic logic [31:0] model_data(input logic [31:0] w, input logic [31:0] pc);
    logic [31:0] a;
    logic [31:0] b;
    logic        is_op;
    a     = model_rf[w[19:15]];
    is_op = (w[6:0] == core_pkg::OPC_OP);
    b     = is_op ? model_rf[w[24:20]] : {{20{w[31]}}, w[31:20]};
    if (w[6:0] == core_pkg::OPC_LUI) return {w[31:12], 12'b0};
    if (w[6:0] == core_pkg::OPC_AUIPC) return pc + {w[31:12], 12'b0};
    if (!is_op && w[6:0] != core_pkg::OPC_OP_IMM) return 32'd0;
    case (w[14:12])
      3'b000:  return (is_op && w[30]) ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return w[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic model_hazard(input logic [31:0] w, input logic [31:0] mask);
    logic has_rs1;
    logic has_rs2;
    has_rs1 = (w[6:0] == core_pkg::OPC_OP) || (w[6:0] == core_pkg::OPC_OP_IMM);
    has_rs2 = (w[6:0] == core_pkg::OPC_OP);
    return (has_rs1 && mask[w[19:15]]) || (has_rs2 && mask[w[24:20]]) || mask[model_rd(w)];
  endfunction

  initial begin
    for (int i = 0; i < 32; i++) model_rf[i] = '0;
  end

  assign res_xfer    = result_valid && result_ready;
  assign accept      = instr_valid && instr_ready;
  assign in_flight   = tail - head;
  assign idle        = (in_flight == {3'b0, res_xfer}); // Empty once this result leaves
  assign word_hazard = model_hazard(instr_word, pend_mask);

  always_comb begin
    exp_rd   = model_rd(buf_word[head[2:0]]);
    exp_data = model_data(buf_word[head[2:0]], buf_pc[head[2:0]]);
  end

  // Destinations still owed by instructions in flight
  always_comb begin
    logic [2:0] slot;
    pend_mask = '0;
    for (int i = 0; i < BUF_DEPTH; i++) begin
      slot = head[2:0] + 3'(i);
      if (i < int'(in_flight) && !(i == 0 && res_xfer)) pend_mask[model_rd(buf_word[slot])] = 1'b1;
    end
    pend_mask[0] = 1'b0;
  end

  always @(posedge clk) begin
    in_reset_q <= !rst;
    if (!rst) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (res_xfer) begin
        head <= head + 4'd1;
        if (exp_rd != 5'd0) model_rf[exp_rd] <= exp_data;
      end
      if (flush) begin
        tail <= head + {3'b0, result_valid}; // Result register survives
      end else if (accept) begin
        buf_word[tail[2:0]] <= instr_word;
        buf_pc[tail[2:0]]   <= instr_pc;
        tail                <= tail + 4'd1;
      end
    end
  end

  reset_quiet: assert property (@(posedge clk) in_reset_q && !rst |-> !instr_ready && !result_valid)
    else begin
      $error("MISMATCH at %0t: handshake high in reset, instr_ready %b result_valid %b",
             $time, $sampled(instr_ready), $sampled(result_valid));
      fail_count++;
    end

  result_match: assert property (@(posedge clk) disable iff (!rst)
    res_xfer |-> in_flight != 0 && result_rd == exp_rd && result_data == exp_data)
    else begin
      $error("MISMATCH at %0t: result x%0d = %h, expected x%0d = %h (%0d in flight)", $time,
             $sampled(result_rd), $sampled(result_data), $sampled(exp_rd), $sampled(exp_data),
             $sampled(in_flight));
      fail_count++;
    end

  result_hold: assert property (@(posedge clk) disable iff (!rst)
    result_valid && !result_ready |=> result_valid && $stable(result_rd) && $stable(result_data))
    else begin
      $error("MISMATCH at %0t: held result changed, now valid %b x%0d = %h", $time,
             $sampled(result_valid), $sampled(result_rd), $sampled(result_data));
      fail_count++;
    end

  hazard_stall: assert property (@(posedge clk) disable iff (!rst)
    instr_valid && word_hazard |-> !instr_ready)
    else begin
      $error("MISMATCH at %0t: instruction %h taken while a register is pending", $time,
             $sampled(instr_word));
      fail_count++;
    end

  issue_latency: assert property (@(posedge clk) disable iff (!rst)
    (accept && idle) ##1 (!flush) [*2] |-> !result_valid ##1 result_valid)
    else begin
      $error("MISMATCH at %0t: result_valid not exactly 3 cycles after issue", $time);
      fail_count++;
    end

endmodule

// File: tests/operand_core_tb.sv
/* Operand core testbench
   Random RV32I stream with register hazards, result back-pressure and flush pulses */
module operand_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_INSTR   = 400;
  localparam int READY_LIMIT = 200;
  localparam int DRAIN_LIMIT = 200;

  logic        clk = 1'b0;
  logic        rst;
  logic        flush;
  logic        instr_valid;
  logic [31:0] instr_word;
  logic [31:0] instr_pc;
  logic        instr_ready;
  logic        result_valid;
  logic        result_ready;
  logic [4:0]  result_rd;
  logic [31:0] result_data;
  logic [15:0] lfsr = 16'd69;
  int          hold_left;

  always #4 clk = ~clk;

  operand_core #(
    .RF_DEPTH(32)
  ) i_operand_core (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .instr_valid (instr_valid),
    .instr_word  (instr_word),
    .instr_pc    (instr_pc),
    .instr_ready (instr_ready),
    .result_valid(result_valid),
    .result_ready(result_ready),
    .result_rd   (result_rd),
    .result_data (result_data)
  );

  bind operand_core operand_core_assert i_operand_core_assert (.*);

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int width, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < width; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // Advance one cycle, then set result_ready and flush
  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk);
    #1;
    if (hold_left > 0) begin
      hold_left--;
      result_ready = 1'b0;
    end else begin
      rand_bits(4, r);
      if (r[3:0] == 4'd0) hold_left = 6; // Long stall fills the slice
      result_ready = (r[3:0] > 4'd2);
    end
    flush = 1'b0;
    if (result_ready) begin // Flush pulses land in drain cycles
      rand_bits(6, r);
      flush = (r[5:0] == 6'd0);
    end
  endtask

  task automatic build_instr(output logic [31:0] word);
    logic [31:0] kind;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] f3;
    logic [31:0] alt;
    logic [31:0] imm;
    logic [11:0] imm12;
    rand_bits(4, kind);
    rand_bits(3, rd);
    rand_bits(3, rs1);
    rand_bits(3, rs2);
    rand_bits(3, f3);
    rand_bits(1, alt);
    rand_bits(20, imm);
    if (f3[1:0] == 2'b01) imm12 = {1'b0, alt[0] && f3[2], 5'b0, imm[4:0]}; // Shift immediates
    else imm12 = imm[11:0];
    if (f3[2:0] != 3'b000 && f3[2:0] != 3'b101) alt = '0;
    if (kind == 11) word = {imm[19:0], rd[4:0], core_pkg::OPC_LUI};
    else if (kind == 12) word = {imm[19:0], rd[4:0], core_pkg::OPC_AUIPC};
    else if (kind == 13) word = {imm[19:0], rd[4:0], 7'b1100011}; // Branch, unsupported
    else if (kind >= 7) word = {imm12, rs1[4:0], f3[2:0], rd[4:0], core_pkg::OPC_OP_IMM};
    else word = {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], core_pkg::OPC_OP};
  endtask

  // Hold the instruction until instr_ready is seen before an edge
  task automatic send_instr(input logic [31:0] word, input logic [31:0] pc);
    int waited;
    waited = 0;
    next_cycle();
    instr_valid = 1'b1;
    instr_word  = word;
    instr_pc    = pc;
    @(negedge clk);
    while (!instr_ready && waited < READY_LIMIT) begin
      next_cycle();
      @(negedge clk);
      waited++;
    end
    if (!instr_ready) abort_run("instr_ready stayed low while an instruction was waiting");
  endtask

  always @(negedge clk) begin
    if (i_operand_core.i_operand_core_assert.fail_count != 0) abort_run("checker assertion failed");
  end

  initial begin
    logic [31:0] word;
    logic [31:0] pc;
    logic [31:0] r;
    int          waited;
    rst          = 1'b0;
    flush        = 1'b0;
    instr_valid  = 1'b0;
    instr_word   = '0;
    instr_pc     = '0;
    result_ready = 1'b0;
    hold_left    = 0;
    pc           = 32'h0000_1000;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b1;
    for (int n = 0; n < NUM_INSTR; n++) begin
      build_instr(word);
      rand_bits(3, r);
      if (r[2:0] == 3'd0) begin // Gap lets the pipeline run empty
        next_cycle();
        instr_valid = 1'b0;
      end
      send_instr(word, pc);
      pc = pc + 32'd4;
    end
    next_cycle();
    instr_valid = 1'b0;
    waited      = 0;
    while (i_operand_core.i_operand_core_assert.in_flight != 0 && waited < DRAIN_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (i_operand_core.i_operand_core_assert.in_flight != 0) begin
      abort_run("results still outstanding after the last instruction");
    end else if (i_operand_core.i_operand_core_assert.fail_count != 0) begin
      abort_run("checker assertion failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// File: Bender.yml
package:
  name: operand_core

sources:
  - logic/core_pkg.sv
  - logic/stream_slice.sv
  - logic/inst_decoder.sv
  - logic/operand_fetch.sv
  - logic/exec_unit.sv
  - logic/operand_core.sv
  - target: test
    files:
      - tests/operand_core_assert.sv
      - tests/operand_core_tb.sv

// File: operand_core.f
logic/core_pkg.sv
logic/stream_slice.sv
logic/inst_decoder.sv
logic/operand_fetch.sv
logic/exec_unit.sv
logic/operand_core.sv
tests/operand_core_assert.sv
tests/operand_core_tb.sv
